//--- common/mcr_input_pkg.sv
package mcr_input_pkg;

	// ==============================
	// Vector types
	// ==============================

	typedef logic [7:0]  byte_t;
	typedef logic [24:0] dl_addr_t;
	typedef logic [7:0]  dl_index_t;

	// Toggle, pressed, extended, scan code
	typedef logic [10:0] ps2_key_t;

	typedef logic [31:0] joy_t;
	typedef logic [15:0] buttons_t;
	typedef logic [7:0]  rst_cnt_t;

	// Game selected by the download select byte
	typedef enum logic [1:0] {
		GAME_SPYHNT = 2'd0,
		GAME_TURBO  = 2'd1,
		GAME_CRATER = 2'd2,
		GAME_NONE   = 2'd3
	} game_t;

	// ==============================
	// Download port
	// ==============================

	localparam dl_index_t IDX_ROM  = 8'd0;
	localparam dl_index_t IDX_GAME = 8'd1;
	localparam dl_index_t IDX_DIP  = 8'd254;

	localparam int DIP_COUNT  = 8;
	localparam int DIP_ADDR_W = $clog2(DIP_COUNT);

	// Second reset pulse comes RST_COUNT_INIT - 1 cycles after release
	localparam rst_cnt_t RST_COUNT_INIT = 8'd64;

	// Emulated analog controls
	localparam byte_t STEER_CENTER = 8'h80;
	localparam byte_t STEER_STEP   = 8'd4;
	localparam byte_t GAS_STEP     = 8'd8;

endpackage

//--- rtl/dl_registers.sv
`timescale 1ns/100ps

module dl_registers import mcr_input_pkg::*; (
	input  logic      clk_sys,
	input  logic      arst_n,
	input  logic      dl_download,
	input  logic      dl_wr,
	input  dl_index_t dl_index,
	input  dl_addr_t  dl_addr,
	input  byte_t     dl_data,
	output game_t     game,
	output byte_t     dip0,
	output logic      service,
	output logic      rom_loaded
);

	byte_t dip_mem [DIP_COUNT];
	byte_t game_sel;
	logic  rom_download;
	logic  rom_dl_q;
	logic  rom_dl_qq;

	assign rom_download = dl_download && (dl_index == IDX_ROM);

	// DIP bytes, addresses past the last byte are dropped
	always_ff @(posedge clk_sys) begin
		if (dl_wr && (dl_index == IDX_DIP) && (dl_addr < DIP_COUNT)) begin
			dip_mem[dl_addr[DIP_ADDR_W-1:0]] <= dl_data;
		end
	end

	assign dip0    = dip_mem[0];
	assign service = dip_mem[1][0];

	// Select byte first, decode on the following cycle
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			game_sel <= 8'hFF;
			game     <= GAME_NONE;
		end else begin
			if (dl_wr && (dl_index == IDX_GAME)) begin
				game_sel <= dl_data;
			end
			case (game_sel)
				8'd0:    game <= GAME_SPYHNT;
				8'd1:    game <= GAME_TURBO;
				8'd2:    game <= GAME_CRATER;
				default: game <= GAME_NONE;
			endcase
		end
	end

	// End of ROM download, sticky until the next arst_n
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rom_dl_q   <= 1'b0;
			rom_dl_qq  <= 1'b0;
			rom_loaded <= 1'b0;
		end else begin
			rom_dl_q  <= rom_download;
			rom_dl_qq <= rom_dl_q;
			if (rom_dl_qq && !rom_dl_q) begin
				rom_loaded <= 1'b1;
			end
		end
	end

endmodule

//--- rtl/reset_gen.sv
`timescale 1ns/100ps

module reset_gen import mcr_input_pkg::*; (
	input  logic clk_sys,
	input  logic arst_n,
	input  logic user_reset,
	input  logic rom_loaded,
	output logic sys_reset
);

	rst_cnt_t count;
	logic     hold;

	// Board stays in reset until the ROM is in place
	assign hold = !rom_loaded || user_reset;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			count     <= RST_COUNT_INIT;
			sys_reset <= 1'b1;
		end else begin
			if (hold) begin
				count <= RST_COUNT_INIT;
			end else if (count != '0) begin
				count <= count - 1'b1;
			end
			// Second one-cycle pulse as the count passes one
			sys_reset <= hold || (count == rst_cnt_t'(1));
		end
	end

endmodule

//--- rtl/kbd_decoder.sv
`timescale 1ns/100ps

module kbd_decoder import mcr_input_pkg::*; (
	input  logic     clk_sys,
	input  logic     arst_n,
	input  ps2_key_t ps2_key,
	output buttons_t buttons
);

	logic  toggle;
	logic  toggle_q;
	logic  pressed;
	byte_t code;

	assign toggle  = ps2_key[10];
	assign pressed = ps2_key[9];
	assign code    = ps2_key[7:0];

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			toggle_q <= 1'b0;
			buttons  <= '0;
		end else begin
			toggle_q <= toggle;
			if (toggle != toggle_q) begin
				case (code)
					// Player 1 arrows
					8'h74: buttons[0] <= pressed;
					8'h6B: buttons[1] <= pressed;
					8'h72: buttons[2] <= pressed;
					8'h75: buttons[3] <= pressed;
					// Fire A to E
					8'h14: buttons[4] <= pressed;
					8'h11: buttons[5] <= pressed;
					8'h29: buttons[6] <= pressed;
					8'h12: buttons[7] <= pressed;
					8'h1A: buttons[8] <= pressed;
					8'h22: buttons[9] <= pressed;
					// ESC and 5 both give coin 1
					8'h76: buttons[10] <= pressed;
					8'h2E: buttons[10] <= pressed;
					8'h36: buttons[11] <= pressed;
					// Player 2 on the letter keys
					8'h34: buttons[12] <= pressed;
					8'h23: buttons[13] <= pressed;
					8'h2B: buttons[14] <= pressed;
					8'h2D: buttons[15] <= pressed;
					// Player 2 fire shares the player 1 fire bits
					8'h1C: buttons[4] <= pressed;
					8'h1B: buttons[5] <= pressed;
					8'h21: buttons[6] <= pressed;
					8'h1D: buttons[7] <= pressed;
					default: ;
				endcase
			end
		end
	end

endmodule

//--- rtl/input_ports.sv
`timescale 1ns/100ps

module input_ports import mcr_input_pkg::*; (
	input  game_t    game,
	input  buttons_t buttons,
	input  joy_t     joy1,
	input  joy_t     joy2,
	input  byte_t    dip0,
	input  logic     service,
	input  logic     steer_sel,
	input  byte_t    steering,
	input  byte_t    gas,
	input  byte_t    spin_angle,
	output byte_t    in0,
	output byte_t    in1,
	output byte_t    in2,
	output byte_t    in3,
	output logic     landscape,
	output logic     ctl_up,
	output logic     ctl_down,
	output logic     ctl_left,
	output logic     ctl_right,
	output logic     spin_ccw,
	output logic     spin_cw
);

	logic  fire_a;
	logic  fire_b;
	logic  fire_c;
	logic  fire_d;
	logic  fire_e;
	logic  shift;
	logic  coin;
	byte_t analog;

	// ==============================
	// Merged controls
	// ==============================

	assign ctl_right = buttons[0] | buttons[12] | joy1[0] | joy2[0];
	assign ctl_left  = buttons[1] | buttons[13] | joy1[1] | joy2[1];
	assign ctl_down  = buttons[2] | buttons[14] | joy1[2] | joy2[2];
	assign ctl_up    = buttons[3] | buttons[15] | joy1[3] | joy2[3];

	assign fire_a = buttons[4] | joy1[4] | joy2[4];
	assign fire_b = buttons[5] | joy1[5] | joy2[5];
	assign fire_c = buttons[6] | joy1[6] | joy2[6];
	assign fire_d = buttons[7] | joy1[7] | joy2[7];
	assign fire_e = buttons[8] | joy1[8] | joy2[8];
	assign shift  = buttons[9] | joy1[9] | joy2[9];
	assign coin   = buttons[10] | buttons[11] | joy1[10] | joy2[10];

	assign spin_ccw = joy1[30] | joy2[30];
	assign spin_cw  = joy1[31] | joy2[31];

	// Board bit 7 of port 4 picks wheel or pedal
	assign analog = steer_sel ? steering : gas;

	// ==============================
	// Per-game port bytes
	// ==============================

	always_comb begin
		landscape = 1'b0;
		in0       = 8'hFF;
		in1       = 8'hFF;
		in2       = 8'hFF;
		in3       = dip0;
		case (game)
			GAME_SPYHNT: begin
				in0 = ~{service, 2'b00, shift, 3'b000, coin};
				in1 = ~{3'b000, fire_a, fire_c, fire_e, fire_b, fire_d};
				in2 = analog;
			end
			GAME_TURBO: begin
				in0 = ~{service, 2'b00, shift, 3'b000, coin};
				in1 = ~{3'b000, fire_e, fire_d, fire_c, fire_b, fire_a};
				in2 = analog;
			end
			GAME_CRATER: begin
				landscape = 1'b1;
				in0 = ~{service, 2'b00, fire_a, fire_e, shift, 1'b0, coin};
				in1 = spin_angle;
				in2 = ~{1'b0, fire_b, 1'b0, fire_c, ctl_down, ctl_up, 2'b00};
			end
			default: ;
		endcase
	end

endmodule

//--- analog_emu/steering_emu.sv
`timescale 1ns/100ps

module steering_emu import mcr_input_pkg::*; (
	input  logic  clk_sys,
	input  logic  arst_n,
	input  logic  sys_reset,
	input  logic  vsync,
	input  logic  gas_plus,
	input  logic  gas_minus,
	input  logic  steer_plus,
	input  logic  steer_minus,
	output byte_t steering,
	output byte_t gas
);

	logic vsync_q;
	logic frame_tick;

	// One step up or down, clamped at both ends
	function automatic byte_t sat_step(byte_t value, logic plus, logic minus, byte_t step);
		byte_t result;
		result = value;
		if (plus && !minus) begin
			result = (value > (8'hFF - step)) ? 8'hFF : value + step;
		end else if (minus && !plus) begin
			result = (value < step) ? 8'h00 : value - step;
		end
		return result;
	endfunction

	assign frame_tick = vsync && !vsync_q;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			vsync_q  <= 1'b0;
			steering <= STEER_CENTER;
			gas      <= '0;
		end else if (sys_reset) begin
			vsync_q  <= vsync;
			steering <= STEER_CENTER;
			gas      <= '0;
		end else begin
			vsync_q <= vsync;
			if (frame_tick) begin
				steering <= sat_step(steering, steer_plus, steer_minus, STEER_STEP);
				gas      <= sat_step(gas, gas_plus, gas_minus, GAS_STEP);
			end
		end
	end

endmodule

//--- analog_emu/spinner_emu.sv
`timescale 1ns/100ps

module spinner_emu import mcr_input_pkg::*; (
	input  logic  clk_sys,
	input  logic  arst_n,
	input  logic  sys_reset,
	input  logic  vsync,
	input  logic  plus,
	input  logic  minus,
	output byte_t spin_angle
);

	logic vsync_q;
	logic frame_tick;

	assign frame_tick = vsync && !vsync_q;

	// Angle wraps freely, one count per frame
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			vsync_q    <= 1'b0;
			spin_angle <= '0;
		end else if (sys_reset) begin
			vsync_q    <= vsync;
			spin_angle <= '0;
		end else begin
			vsync_q <= vsync;
			if (frame_tick) begin
				if (plus && !minus) begin
					spin_angle <= spin_angle + 8'd1;
				end else if (minus && !plus) begin
					spin_angle <= spin_angle - 8'd1;
				end
			end
		end
	end

endmodule

//--- rtl/mcr_input_top.sv
`timescale 1ns/100ps

module mcr_input_top import mcr_input_pkg::*; (
	input  logic      clk_sys,
	input  logic      arst_n,
	input  logic      user_reset,
	input  logic      dl_download,
	input  logic      dl_wr,
	input  dl_index_t dl_index,
	input  dl_addr_t  dl_addr,
	input  byte_t     dl_data,
	input  ps2_key_t  ps2_key,
	input  joy_t      joy1,
	input  joy_t      joy2,
	input  logic      vsync,
	input  logic      steer_sel,
	output byte_t     in0,
	output byte_t     in1,
	output byte_t     in2,
	output byte_t     in3,
	output logic      landscape,
	output logic      sys_reset
);

	game_t    game;
	byte_t    dip0;
	logic     service;
	logic     rom_loaded;
	buttons_t buttons;
	byte_t    steering;
	byte_t    gas;
	byte_t    spin_angle;
	logic     ctl_up;
	logic     ctl_down;
	logic     ctl_left;
	logic     ctl_right;
	logic     spin_ccw;
	logic     spin_cw;

	// ==============================
	// Download and reset
	// ==============================

	dl_registers u_dl_registers (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.dl_download (dl_download),
		.dl_wr       (dl_wr),
		.dl_index    (dl_index),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.game        (game),
		.dip0        (dip0),
		.service     (service),
		.rom_loaded  (rom_loaded)
	);

	reset_gen u_reset_gen (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.user_reset (user_reset),
		.rom_loaded (rom_loaded),
		.sys_reset  (sys_reset)
	);

	// ==============================
	// Player controls
	// ==============================

	kbd_decoder u_kbd_decoder (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.ps2_key (ps2_key),
		.buttons (buttons)
	);

	input_ports u_input_ports (
		.game       (game),
		.buttons    (buttons),
		.joy1       (joy1),
		.joy2       (joy2),
		.dip0       (dip0),
		.service    (service),
		.steer_sel  (steer_sel),
		.steering   (steering),
		.gas        (gas),
		.spin_angle (spin_angle),
		.in0        (in0),
		.in1        (in1),
		.in2        (in2),
		.in3        (in3),
		.landscape  (landscape),
		.ctl_up     (ctl_up),
		.ctl_down   (ctl_down),
		.ctl_left   (ctl_left),
		.ctl_right  (ctl_right),
		.spin_ccw   (spin_ccw),
		.spin_cw    (spin_cw)
	);

	// Up and down work the pedal, left and right the wheel
	steering_emu u_steering_emu (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.sys_reset   (sys_reset),
		.vsync       (vsync),
		.gas_plus    (ctl_up),
		.gas_minus   (ctl_down),
		.steer_plus  (ctl_right),
		.steer_minus (ctl_left),
		.steering    (steering),
		.gas         (gas)
	);

	spinner_emu u_spinner_emu (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.sys_reset  (sys_reset),
		.vsync      (vsync),
		.plus       (ctl_right | spin_cw),
		.minus      (ctl_left | spin_ccw),
		.spin_angle (spin_angle)
	);

endmodule

//--- test/mcr_input_asserts.sv
`timescale 1ns/100ps

module mcr_input_asserts import mcr_input_pkg::*; (
	input logic  clk_sys,
	input logic  arst_n,
	input logic  user_reset,
	input logic  rom_loaded,
	input logic  sys_reset,
	input logic  landscape,
	input game_t game
);

	int assert_errors = 0;

	// Board held in reset until the ROM is in place
	hold_until_loaded: assert property (
		@(posedge clk_sys) disable iff (!arst_n) !rom_loaded |-> sys_reset
	) else begin
		$error("sys_reset low while the ROM is not loaded");
		assert_errors++;
	end

	crater_landscape: assert property (
		@(posedge clk_sys) disable iff (!arst_n) landscape |-> (game == GAME_CRATER)
	) else begin
		$error("landscape high outside the crater game");
		assert_errors++;
	end

	// Second reset after load is a single cycle
	single_cycle_pulse: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		($rose(sys_reset) && rom_loaded && !user_reset) |=> !sys_reset
	) else begin
		$error("sys_reset pulse after load lasted more than one cycle");
		assert_errors++;
	end

endmodule

bind mcr_input_top mcr_input_asserts u_asserts (
	.clk_sys    (clk_sys),
	.arst_n     (arst_n),
	.user_reset (user_reset),
	.rom_loaded (rom_loaded),
	.sys_reset  (sys_reset),
	.landscape  (landscape),
	.game       (game)
);

//--- test/tb_mcr_input.sv
`timescale 1ns/100ps

module tb_mcr_input import mcr_input_pkg::*; ();

	logic      clk_sys;
	logic      arst_n;
	logic      user_reset;
	logic      dl_download;
	logic      dl_wr;
	dl_index_t dl_index;
	dl_addr_t  dl_addr;
	byte_t     dl_data;
	ps2_key_t  ps2_key;
	joy_t      joy1;
	joy_t      joy2;
	logic      vsync;
	logic      steer_sel;
	byte_t     in0;
	byte_t     in1;
	byte_t     in2;
	byte_t     in3;
	logic      landscape;
	logic      sys_reset;
	integer    seed;

	mcr_input_top u_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ==============================
	// Helpers
	// ==============================

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, actual, expected);
			$display("=== FAIL ===");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("Timed out waiting for %s", what);
		$display("=== FAIL ===");
		$fatal(1, "Stopped on timeout");
	endtask

	task automatic dl_write(input dl_index_t idx, input dl_addr_t addr, input byte_t data);
		dl_wr    = 1'b1;
		dl_index = idx;
		dl_addr  = addr;
		dl_data  = data;
		next_cycle();
		dl_wr = 1'b0;
	endtask

	task automatic select_game(input byte_t sel);
		dl_write(IDX_GAME, '0, sel);
		next_cycle();
		next_cycle();
	endtask

	// New key event marked by flipping the toggle bit
	task automatic send_key(input byte_t code, input logic pressed);
		ps2_key = {~ps2_key[10], pressed, 1'b0, code};
		next_cycle();
		next_cycle();
	endtask

	task automatic vsync_pulse();
		vsync = 1'b1;
		next_cycle();
		next_cycle();
		vsync = 1'b0;
		next_cycle();
	endtask

	// Fire vector f holds A in bit 0 up to E in bit 4
	function automatic byte_t spy_in0(input logic svc, input logic shift, input logic coin);
		return ~{svc, 2'b00, shift, 3'b000, coin};
	endfunction

	function automatic byte_t spy_in1(input logic [4:0] f);
		return ~{3'b000, f[0], f[2], f[4], f[1], f[3]};
	endfunction

	function automatic byte_t turbo_in1(input logic [4:0] f);
		return ~{3'b000, f[4], f[3], f[2], f[1], f[0]};
	endfunction

	function automatic byte_t crater_in2(input logic b, input logic c, input logic down,
			input logic up);
		return ~{1'b0, b, 1'b0, c, down, up, 2'b00};
	endfunction

	function automatic byte_t sat_add(input byte_t value, input byte_t step);
		int sum;
		sum = int'(value) + int'(step);
		return (sum > 255) ? 8'hFF : byte_t'(sum);
	endfunction

	// ==============================
	// Directed tests
	// ==============================

	task automatic reset_and_load();
		int n;
		int i;
		repeat (3) next_cycle();
		check("sys_reset", sys_reset, 1'b1);
		dl_download = 1'b1;
		for (i = 0; i < 4; i++) begin
			dl_write(IDX_ROM, dl_addr_t'(i), byte_t'(8'hC0 + i));
		end
		dl_download = 1'b0;
		n = 0;
		while (sys_reset && n < 20) begin
			next_cycle();
			n++;
		end
		if (sys_reset) timeout_fail("sys_reset to fall after the ROM download");
		n = 0;
		while (!sys_reset && n < 200) begin
			next_cycle();
			n++;
		end
		if (!sys_reset) timeout_fail("the second reset pulse");
		check("second pulse delay", n, int'(RST_COUNT_INIT) - 1);
		for (i = 0; i < 100; i++) begin
			next_cycle();
			check("sys_reset", sys_reset, 1'b0);
		end
	endtask

	task automatic download_registers();
		dl_write(IDX_DIP, 25'd0, 8'h5A);
		check("in3", in3, 8'h5A);
		dl_write(IDX_DIP, 25'd1, 8'h01);
		// Address past the DIP bytes is ignored
		dl_write(IDX_DIP, 25'd8, 8'hFF);
		check("in3", in3, 8'h5A);
		select_game(8'd0);
		check("in0[7]", in0[7], 1'b0);
	endtask

	task automatic spyhunter_keys();
		logic [4:0] rnd1;
		logic [4:0] rnd2;
		int i;
		send_key(8'h14, 1'b1);
		check("in1", in1, spy_in1(5'b00001));
		send_key(8'h12, 1'b1);
		check("in1", in1, spy_in1(5'b01001));
		send_key(8'h76, 1'b1);
		check("in0", in0, spy_in0(1'b1, 1'b0, 1'b1));
		send_key(8'h14, 1'b0);
		check("in1", in1, spy_in1(5'b01000));
		send_key(8'h12, 1'b0);
		check("in1", in1, spy_in1(5'b00000));
		send_key(8'h76, 1'b0);
		check("in0", in0, spy_in0(1'b1, 1'b0, 1'b0));
		// Keyboard fire A held with random joystick fire bits
		send_key(8'h14, 1'b1);
		for (i = 0; i < 6; i++) begin
			rnd1 = 5'($random(seed));
			rnd2 = 5'($random(seed));
			joy1 = '0;
			joy2 = '0;
			joy1[8:4] = rnd1;
			joy2[8:4] = rnd2;
			next_cycle();
			check("in1", in1, spy_in1(5'b00001 | rnd1 | rnd2));
		end
		joy1 = '0;
		joy2 = '0;
		send_key(8'h14, 1'b0);
	endtask

	task automatic turbo_ports();
		byte_t exp;
		int i;
		select_game(8'd1);
		check("landscape", landscape, 1'b0);
		joy1[4] = 1'b1;
		joy1[6] = 1'b1;
		next_cycle();
		check("in1", in1, turbo_in1(5'b00101));
		// Pedal on up until it passes the top of the range
		joy1 = '0;
		joy1[3] = 1'b1;
		steer_sel = 1'b0;
		exp = 8'h00;
		for (i = 0; i < 36; i++) begin
			vsync_pulse();
			exp = sat_add(exp, GAS_STEP);
			check("in2 gas", in2, exp);
		end
		joy1 = '0;
		joy1[0] = 1'b1;
		steer_sel = 1'b1;
		next_cycle();
		exp = STEER_CENTER;
		check("in2 steering", in2, exp);
		for (i = 0; i < 10; i++) begin
			vsync_pulse();
			exp = sat_add(exp, STEER_STEP);
			check("in2 steering", in2, exp);
		end
		// Spinning the angle back to zero leaves the wheel alone
		joy1 = '0;
		joy1[30] = 1'b1;
		for (i = 0; i < 10; i++) begin
			vsync_pulse();
		end
		check("in2 steering", in2, exp);
		joy1 = '0;
	endtask

	task automatic crater_ports();
		int i;
		select_game(8'd2);
		check("landscape", landscape, 1'b1);
		check("in1 spin", in1, 8'h00);
		joy1[31] = 1'b1;
		for (i = 0; i < 300; i++) begin
			vsync_pulse();
		end
		check("in1 spin", in1, 300 % 256);
		joy1 = '0;
		joy1[3] = 1'b1;
		next_cycle();
		check("in2", in2, crater_in2(1'b0, 1'b0, 1'b0, 1'b1));
		joy1 = '0;
		joy1[2] = 1'b1;
		joy1[6] = 1'b1;
		next_cycle();
		check("in2", in2, crater_in2(1'b0, 1'b1, 1'b1, 1'b0));
		joy1 = '0;
	endtask

	initial begin
		seed        = 32'hd352_6f2c;
		arst_n      = 1'b0;
		user_reset  = 1'b0;
		dl_download = 1'b0;
		dl_wr       = 1'b0;
		dl_index    = '0;
		dl_addr     = '0;
		dl_data     = '0;
		ps2_key     = '0;
		joy1        = '0;
		joy2        = '0;
		vsync       = 1'b0;
		steer_sel   = 1'b0;
		repeat (2) @(posedge clk_sys);
		#1;
		arst_n = 1'b1;
		reset_and_load();
		download_registers();
		spyhunter_keys();
		turbo_ports();
		crater_ports();
		if (u_dut.u_asserts.assert_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- mcr_input.f
common/mcr_input_pkg.sv
rtl/dl_registers.sv
rtl/reset_gen.sv
rtl/kbd_decoder.sv
rtl/input_ports.sv
analog_emu/steering_emu.sv
analog_emu/spinner_emu.sv
rtl/mcr_input_top.sv
test/mcr_input_asserts.sv
test/tb_mcr_input.sv
